/* tb.f */
hw/axi_pkg.sv
hw/bram_pkg.sv
hw/input_buffer.sv
hw/output_buffer.sv
hw/axi_bram_reader.sv
hw/axi_bram_writer.sv
hw/bram_dual.sv
hw/bram_subsystem.sv
tb/bram_checker.sv
tb/tb_bram_subsystem.sv

/* Makefile */
TOP := tb_bram_subsystem

.PHONY: sim clean

sim:
	verilator --binary -f tb.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb/tb_bram_subsystem.sv */
`timescale 1ns/1ps

module tb_bram_subsystem import axi_pkg::*;;

  typedef struct packed {
    logic                      is_wr;
    logic [AXI_ADDR_WIDTH-1:0] addr;
    logic [AXI_DATA_WIDTH-1:0] data;
    logic [AXI_STRB_WIDTH-1:0] strb;
    int                        skew;   // W start minus AW start, in cycles
    logic [AXI_DATA_WIDTH-1:0] exp;    // Read result by the strobe and alias rules
  } op_t;

  localparam int NUM_OPS     = 30;
  localparam int CYCLE_LIMIT = NUM_OPS * 40;

  op_t ops [NUM_OPS] = '{
    // Full words on every tested address, skew in both orders
    '{1'b1, 16'h0000, 32'h1122_3344, 4'hF,  0, 32'h0},
    '{1'b1, 16'h0004, 32'h5566_7788, 4'hF,  1, 32'h0},
    '{1'b1, 16'h0040, 32'h9ABC_DEF0, 4'hF, -1, 32'h0},
    '{1'b1, 16'h0FFC, 32'h0BAD_F00D, 4'hF,  2, 32'h0},
    '{1'b1, 16'h0554, 32'hCAFE_BABE, 4'hF, -2, 32'h0},
    '{1'b0, 16'h0000, 32'h0,         4'h0,  0, 32'h1122_3344},
    '{1'b0, 16'h0004, 32'h0,         4'h0,  0, 32'h5566_7788},
    '{1'b0, 16'h0040, 32'h0,         4'h0,  0, 32'h9ABC_DEF0},
    '{1'b0, 16'h0FFC, 32'h0,         4'h0,  0, 32'h0BAD_F00D},
    '{1'b0, 16'h0554, 32'h0,         4'h0,  0, 32'hCAFE_BABE},
    // Partial strobes
    '{1'b1, 16'h0000, 32'hAABB_CCDD, 4'h1,  1, 32'h0},
    '{1'b0, 16'h0000, 32'h0,         4'h0,  0, 32'h1122_33DD},
    '{1'b1, 16'h0004, 32'h1234_5678, 4'hA, -1, 32'h0},
    '{1'b0, 16'h0004, 32'h0,         4'h0,  0, 32'h1266_5688},
    '{1'b1, 16'h0040, 32'hFFEE_DDCC, 4'h6,  2, 32'h0},
    '{1'b0, 16'h0040, 32'h0,         4'h0,  0, 32'h9AEE_DDF0},
    '{1'b1, 16'h0040, 32'h0,         4'h0,  0, 32'h0},
    '{1'b0, 16'h0040, 32'h0,         4'h0,  0, 32'h9AEE_DDF0},
    // Aliasing above 4 KiB and ignored byte offsets
    '{1'b1, 16'h1FFC, 32'h1357_9BDF, 4'hF, -2, 32'h0},
    '{1'b0, 16'h0FFC, 32'h0,         4'h0,  0, 32'h1357_9BDF},
    '{1'b0, 16'hF003, 32'h0,         4'h0,  0, 32'h1122_33DD},
    '{1'b1, 16'h2555, 32'h0F0F_0F0F, 4'hC,  1, 32'h0},
    '{1'b0, 16'h0556, 32'h0,         4'h0,  0, 32'h0F0F_BABE},
    '{1'b0, 16'h8007, 32'h0,         4'h0,  0, 32'h1266_5688},
    '{1'b1, 16'h0006, 32'hDEAD_BEEF, 4'h8, -1, 32'h0},
    '{1'b0, 16'h4004, 32'h0,         4'h0,  0, 32'hDE66_5688},
    '{1'b0, 16'h1FFF, 32'h0,         4'h0,  0, 32'h1357_9BDF},
    '{1'b1, 16'hFFFC, 32'h2468_1357, 4'hF,  0, 32'h0},
    '{1'b0, 16'h0FFC, 32'h0,         4'h0,  0, 32'h2468_1357},
    '{1'b0, 16'h0000, 32'h0,         4'h0,  0, 32'h1122_33DD}
  };

  logic                      aclk;
  logic                      rst;
  logic [AXI_ADDR_WIDTH-1:0] awaddr;
  logic                      awvalid;
  logic                      awready;
  logic [AXI_DATA_WIDTH-1:0] wdata;
  logic [AXI_STRB_WIDTH-1:0] wstrb;
  logic                      wvalid;
  logic                      wready;
  logic [1:0]                bresp;
  logic                      bvalid;
  logic                      bready;
  logic [AXI_ADDR_WIDTH-1:0] araddr;
  logic                      arvalid;
  logic                      arready;
  logic [AXI_DATA_WIDTH-1:0] rdata;
  logic [1:0]                rresp;
  logic                      rvalid;
  logic                      rready;
  logic [AXI_DATA_WIDTH-1:0] ref_rdata;
  logic                      bp_en;         // Random bready and rready
  int                        error_count;
  int                        b_count;
  int                        r_count;
  int                        count_errors;
  int                        cycle_count;

  bram_subsystem i_bram_subsystem (.*);

  bram_checker i_bram_checker (.*);

  initial begin
    aclk = 1'b0;
    forever #50 aclk = ~aclk;
  end

  task automatic drive_ready_noise();
    forever begin
      @(posedge aclk);
      bready <= bp_en ? (($urandom % 3) != 0) : 1'b1;  // Low about one cycle in three
      rready <= bp_en ? (($urandom % 3) != 0) : 1'b1;
    end
  endtask

  task automatic write_word(input op_t op);
    int   aw_delay;
    int   w_delay;
    int   cyc;
    logic aw_left;
    logic w_left;
    aw_delay = (op.skew < 0) ? -op.skew : 0;
    w_delay  = (op.skew > 0) ? op.skew : 0;
    aw_left  = 1'b1;
    w_left   = 1'b1;
    cyc      = 0;
    while (aw_left || w_left) begin
      if (aw_left && !awvalid && cyc >= aw_delay) begin
        awaddr  <= op.addr;
        awvalid <= 1'b1;
      end
      if (w_left && !wvalid && cyc >= w_delay) begin
        wdata  <= op.data;
        wstrb  <= op.strb;
        wvalid <= 1'b1;
      end
      @(posedge aclk);
      cyc++;
      if (awvalid && awready) begin
        awvalid <= 1'b0;
        aw_left = 1'b0;
      end
      if (wvalid && wready) begin
        wvalid <= 1'b0;
        w_left = 1'b0;
      end
    end
    do @(posedge aclk); while (!(bvalid && bready));
  endtask

  task automatic read_word(input op_t op);
    araddr    <= op.addr;
    arvalid   <= 1'b1;
    ref_rdata <= op.exp;
    do @(posedge aclk); while (!(arvalid && arready));
    arvalid <= 1'b0;
    do @(posedge aclk); while (!(rvalid && rready));
  endtask

  initial begin
    int n_writes;
    int n_reads;
    void'($urandom(32'hcd3c8d68));
    rst       = 1'b1;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wstrb     = '0;
    wvalid    = 1'b0;
    bready    = 1'b1;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b1;
    ref_rdata = '0;
    bp_en     = 1'b0;
    count_errors = 0;
    n_writes  = 0;
    n_reads   = 0;
    fork
      drive_ready_noise();
    join_none
    repeat (5) @(posedge aclk);
    rst <= 1'b0;
    @(posedge aclk);
    for (int i = 0; i < NUM_OPS; i++) begin
      bp_en <= (i >= 10);                                // First entries run without stalls
      if (ops[i].is_wr) begin
        n_writes++;
        write_word(ops[i]);
      end else begin
        n_reads++;
        read_word(ops[i]);
      end
    end
    repeat (3) @(posedge aclk);
    if (b_count != n_writes) begin
      $display("[FAIL] t=%0t b_count expected %0d got %0d", $time, n_writes, b_count);
      count_errors++;
    end
    if (r_count != n_reads) begin
      $display("[FAIL] t=%0t r_count expected %0d got %0d", $time, n_reads, r_count);
      count_errors++;
    end
    $display("Summary: %0d checker errors, %0d count errors, %0d B and %0d R transfers",
             error_count, count_errors, b_count, r_count);
    if (error_count == 0 && count_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  always @(posedge aclk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the table did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Summary: %0d checker errors, %0d count errors, %0d B and %0d R transfers",
               error_count, count_errors, b_count, r_count);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

endmodule

/* tb/bram_checker.sv */
`timescale 1ns/1ps

module bram_checker import axi_pkg::*, bram_pkg::*; (
  input  logic                      aclk,
  input  logic                      rst,
  input  logic [AXI_ADDR_WIDTH-1:0] awaddr,
  input  logic                      awvalid,
  input  logic                      awready,
  input  logic [AXI_DATA_WIDTH-1:0] wdata,
  input  logic [AXI_STRB_WIDTH-1:0] wstrb,
  input  logic                      wvalid,
  input  logic                      wready,
  input  logic [1:0]                bresp,
  input  logic                      bvalid,
  input  logic                      bready,
  input  logic [AXI_ADDR_WIDTH-1:0] araddr,
  input  logic                      arvalid,
  input  logic                      arready,
  input  logic [AXI_DATA_WIDTH-1:0] rdata,
  input  logic [1:0]                rresp,
  input  logic                      rvalid,
  input  logic                      rready,
  input  logic [AXI_DATA_WIDTH-1:0] ref_rdata,   // Read result from the stimulus table
  output int                        error_count,
  output int                        b_count,
  output int                        r_count
);

  logic [BRAM_DATA_WIDTH-1:0] shadow [2**BRAM_ADDR_WIDTH];
  bit                         known  [2**BRAM_ADDR_WIDTH];  // Word written at least once
  logic [BRAM_ADDR_WIDTH-1:0] aw_q  [$];
  logic [AXI_DATA_WIDTH-1:0]  wd_q  [$];
  logic [AXI_STRB_WIDTH-1:0]  ws_q  [$];
  logic [AXI_DATA_WIDTH-1:0]  exp_q [$];
  logic [AXI_DATA_WIDTH-1:0]  ref_q [$];
  logic                       aw_seen;
  logic                       w_seen;
  logic                       b_due;          // bvalid must be high at this edge
  logic                       r_due;          // rvalid must be high at this edge
  logic                       b_hold;
  logic                       r_hold;
  logic [AXI_DATA_WIDTH-1:0]  held_rdata;

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("[FAIL] t=%0t %s expected %h got %h", $time, name, expected, actual);
    error_count++;
  endtask

  task automatic report_problem(input string what);
    $display("Error at t=%0t: %s", $time, what);
    error_count++;
  endtask

  // Values are sampled at the rising edge, before the DUT updates
  always @(posedge aclk) begin
    logic [BRAM_ADDR_WIDTH-1:0] word;
    logic [AXI_DATA_WIDTH-1:0]  merged;
    logic [AXI_DATA_WIDTH-1:0]  wd;
    logic [AXI_STRB_WIDTH-1:0]  ws;
    if (rst) begin
      aw_q.delete();
      wd_q.delete();
      ws_q.delete();
      exp_q.delete();
      ref_q.delete();
      {aw_seen, w_seen, b_due, r_due, b_hold, r_hold} = '0;
      error_count = 0;
      b_count     = 0;
      r_count     = 0;
    end else begin
      if (r_due && !rvalid) report_problem("rvalid did not rise one cycle after the AR transfer");
      if (b_due && !bvalid) report_problem("bvalid did not rise one cycle after AW and W");
      if (r_hold && !rvalid) begin
        report_problem("rvalid dropped before the R transfer");
      end else if (r_hold && rdata !== held_rdata) begin
        report_mismatch("rdata", held_rdata, rdata);      // Changed while stalled
      end
      if (b_hold && !bvalid) report_problem("bvalid dropped before the B transfer");
      r_due = 1'b0;
      b_due = 1'b0;

      if (awvalid && awready) begin
        aw_q.push_back(awaddr[ADDR_LSB +: BRAM_ADDR_WIDTH]);  // Upper bits alias away
        aw_seen = 1'b1;
      end
      if (wvalid && wready) begin
        wd_q.push_back(wdata);
        ws_q.push_back(wstrb);
        w_seen = 1'b1;
      end
      if (aw_seen && w_seen) begin
        b_due   = !bvalid || bready;                      // Only when the B stage is free
        aw_seen = 1'b0;
        w_seen  = 1'b0;
      end

      if (bvalid && bready) begin
        b_count++;
        if (bresp !== RESP_OKAY) report_mismatch("bresp", 32'(RESP_OKAY), {30'b0, bresp});
        if (aw_q.size() == 0 || wd_q.size() == 0) begin
          report_problem("B transfer with no complete write outstanding");
        end else begin
          word   = aw_q.pop_front();
          wd     = wd_q.pop_front();
          ws     = ws_q.pop_front();
          merged = shadow[word];
          for (int i = 0; i < AXI_STRB_WIDTH; i++) begin
            if (ws[i]) merged[i*8 +: 8] = wd[i*8 +: 8];   // Strobed bytes only
          end
          shadow[word] = merged;
          known[word]  = 1'b1;
        end
      end

      if (rvalid && rready) begin
        r_count++;
        if (rresp !== RESP_OKAY) report_mismatch("rresp", 32'(RESP_OKAY), {30'b0, rresp});
        if (exp_q.size() == 0) begin
          report_problem("R transfer with no read outstanding");
        end else begin
          merged = exp_q.pop_front();
          wd     = ref_q.pop_front();
          if (rdata !== merged) report_mismatch("rdata", merged, rdata);
          if (rdata !== wd) report_mismatch("rdata (table)", wd, rdata);
        end
      end
      if (arvalid && arready) begin
        word = araddr[ADDR_LSB +: BRAM_ADDR_WIDTH];
        if (!known[word]) report_problem("read of a word that no write has set");
        exp_q.push_back(shadow[word]);
        ref_q.push_back(ref_rdata);
        r_due = !rvalid || rready;
      end

      r_hold     = rvalid && !rready;
      b_hold     = bvalid && !bready;
      held_rdata = rdata;
    end
  end

endmodule

/* hw/bram_subsystem.sv */
`timescale 1ns/1ps

module bram_subsystem import axi_pkg::*, bram_pkg::*; (
  input  logic                      aclk,
  input  logic                      rst,

  // Write address channel
  input  logic [AXI_ADDR_WIDTH-1:0] awaddr,
  input  logic                      awvalid,
  output logic                      awready,

  // Write data channel
  input  logic [AXI_DATA_WIDTH-1:0] wdata,
  input  logic [AXI_STRB_WIDTH-1:0] wstrb,
  input  logic                      wvalid,
  output logic                      wready,

  // Write response channel
  output logic [1:0]                bresp,
  output logic                      bvalid,
  input  logic                      bready,

  // Read address channel
  input  logic [AXI_ADDR_WIDTH-1:0] araddr,
  input  logic                      arvalid,
  output logic                      arready,

  // Read data channel
  output logic [AXI_DATA_WIDTH-1:0] rdata,
  output logic [1:0]                rresp,
  output logic                      rvalid,
  input  logic                      rready
);

  logic                       wr_en;
  logic [BRAM_WE_WIDTH-1:0]   wr_we;
  logic [BRAM_ADDR_WIDTH-1:0] wr_addr;
  logic [BRAM_DATA_WIDTH-1:0] wr_data;
  logic                       rd_en;
  logic [BRAM_ADDR_WIDTH-1:0] rd_addr;
  logic [BRAM_DATA_WIDTH-1:0] rd_data;

  axi_bram_writer i_writer (
    .aclk    (aclk),
    .rst     (rst),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .wr_en   (wr_en),
    .wr_we   (wr_we),
    .wr_addr (wr_addr),
    .wr_data (wr_data)
  );

  axi_bram_reader i_reader (
    .aclk    (aclk),
    .rst     (rst),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  bram_dual i_bram (
    .aclk    (aclk),
    .wr_en   (wr_en),
    .wr_we   (wr_we),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

/* hw/bram_dual.sv */
`timescale 1ns/1ps

module bram_dual import bram_pkg::*; (
  input  logic                       aclk,

  // Write port
  input  logic                       wr_en,
  input  logic [BRAM_WE_WIDTH-1:0]   wr_we,    // One enable per byte lane
  input  logic [BRAM_ADDR_WIDTH-1:0] wr_addr,
  input  logic [BRAM_DATA_WIDTH-1:0] wr_data,

  // Read port
  input  logic                       rd_en,
  input  logic [BRAM_ADDR_WIDTH-1:0] rd_addr,
  output logic [BRAM_DATA_WIDTH-1:0] rd_data   // Valid the cycle after rd_en
);

  logic [BRAM_DATA_WIDTH-1:0] mem [2**BRAM_ADDR_WIDTH];

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      for (int i = 0; i < BRAM_WE_WIDTH; i++) begin
        if (wr_we[i]) begin
          mem[wr_addr][i*8 +: 8] <= wr_data[i*8 +: 8];
        end
      end
    end
  end

  // Output register only moves on rd_en, so it holds the last word
  // while the reader is stalled. A read colliding with a write to the
  // same word sees the old contents.
  always_ff @(posedge aclk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

/* hw/axi_bram_writer.sv */
`timescale 1ns/1ps

module axi_bram_writer import axi_pkg::*, bram_pkg::*; (
  input  logic                       aclk,
  input  logic                       rst,

  // AXI4-Lite write channels
  input  logic [AXI_ADDR_WIDTH-1:0]  awaddr,
  input  logic                       awvalid,
  output logic                       awready,
  input  logic [AXI_DATA_WIDTH-1:0]  wdata,
  input  logic [AXI_STRB_WIDTH-1:0]  wstrb,
  input  logic                       wvalid,
  output logic                       wready,
  output logic [1:0]                 bresp,
  output logic                       bvalid,
  input  logic                       bready,

  // BRAM write port
  output logic                       wr_en,
  output logic [BRAM_WE_WIDTH-1:0]   wr_we,
  output logic [BRAM_ADDR_WIDTH-1:0] wr_addr,
  output logic [BRAM_DATA_WIDTH-1:0] wr_data
);

  logic [AXI_ADDR_WIDTH-1:0]                int_awaddr;
  logic                                     int_awvalid;
  logic [AXI_STRB_WIDTH+AXI_DATA_WIDTH-1:0] int_wpayload;  // {strobes, data}
  logic                                     int_wvalid;
  logic                                     int_bready;    // B stage can accept
  logic                                     fire;

  input_buffer #(
    .payload_t(logic [AXI_ADDR_WIDTH-1:0])
  ) i_aw_buf (
    .aclk      (aclk),
    .rst       (rst),
    .in_data   (awaddr),
    .in_valid  (awvalid),
    .in_ready  (awready),
    .out_data  (int_awaddr),
    .out_valid (int_awvalid),
    .out_ready (int_wvalid && int_bready)   // Wait for the data beat
  );

  input_buffer #(
    .payload_t(logic [AXI_STRB_WIDTH+AXI_DATA_WIDTH-1:0])
  ) i_w_buf (
    .aclk      (aclk),
    .rst       (rst),
    .in_data   ({wstrb, wdata}),
    .in_valid  (wvalid),
    .in_ready  (wready),
    .out_data  (int_wpayload),
    .out_valid (int_wvalid),
    .out_ready (int_awvalid && int_bready)  // Wait for the address
  );

  output_buffer i_b_buf (
    .aclk      (aclk),
    .rst       (rst),
    .in_valid  (int_awvalid && int_wvalid),
    .in_ready  (int_bready),
    .out_valid (bvalid),
    .out_ready (bready)
  );

  // Whichever channel shows up first waits in its skid register until the
  // other one joins. Both leave together with the memory write.
  assign fire = int_awvalid && int_wvalid && int_bready;

  assign wr_en   = fire;
  assign wr_we   = int_wpayload[AXI_DATA_WIDTH +: AXI_STRB_WIDTH];  // Strobes as byte enables
  assign wr_addr = int_awaddr[ADDR_LSB +: BRAM_ADDR_WIDTH];
  assign wr_data = int_wpayload[AXI_DATA_WIDTH-1:0];

  assign bresp = RESP_OKAY;

endmodule

/* hw/axi_bram_reader.sv */
`timescale 1ns/1ps

module axi_bram_reader import axi_pkg::*, bram_pkg::*; (
  input  logic                       aclk,
  input  logic                       rst,

  // AXI4-Lite read channels
  input  logic [AXI_ADDR_WIDTH-1:0]  araddr,
  input  logic                       arvalid,
  output logic                       arready,
  output logic [AXI_DATA_WIDTH-1:0]  rdata,
  output logic [1:0]                 rresp,
  output logic                       rvalid,
  input  logic                       rready,

  // BRAM read port
  output logic                       rd_en,
  output logic [BRAM_ADDR_WIDTH-1:0] rd_addr,
  input  logic [BRAM_DATA_WIDTH-1:0] rd_data
);

  logic [AXI_ADDR_WIDTH-1:0] int_araddr;
  logic                      int_arvalid;
  logic                      int_rready;   // R stage can take a new word

  input_buffer #(
    .payload_t(logic [AXI_ADDR_WIDTH-1:0])
  ) i_ar_buf (
    .aclk      (aclk),
    .rst       (rst),
    .in_data   (araddr),
    .in_valid  (arvalid),
    .in_ready  (arready),
    .out_data  (int_araddr),
    .out_valid (int_arvalid),
    .out_ready (int_rready)
  );

  output_buffer i_r_buf (
    .aclk      (aclk),
    .rst       (rst),
    .in_valid  (int_arvalid),
    .in_ready  (int_rready),
    .out_valid (rvalid),
    .out_ready (rready)
  );

  // Memory read fires in the same cycle the address moves into the R stage,
  // so the registered memory output lines up with rvalid. While the master
  // stalls R the enable stays low and the memory output holds rdata.
  assign rd_en   = int_arvalid && int_rready;
  assign rd_addr = int_araddr[ADDR_LSB +: BRAM_ADDR_WIDTH];  // Upper bits alias

  assign rdata = rd_data;
  assign rresp = RESP_OKAY;

endmodule

/* hw/output_buffer.sv */
`timescale 1ns/1ps

module output_buffer (
  input  logic aclk,
  input  logic rst,

  input  logic in_valid,
  output logic in_ready,    // Free, or the pending response leaves now

  output logic out_valid,
  input  logic out_ready
);

  logic pending;            // Response waiting for the master

  // Whenever the stage can accept, its next state is simply whether a new
  // request comes in. Otherwise the pending response is held.
  always_ff @(posedge aclk) begin
    if (rst) begin
      pending <= 1'b0;
    end else if (in_ready) begin
      pending <= in_valid;  // Set on transfer in, clear on transfer out
    end
  end

  assign in_ready  = !pending || out_ready;
  assign out_valid = pending;

endmodule

/* hw/input_buffer.sv */
`timescale 1ns/1ps

module input_buffer #(
  parameter type payload_t = logic
) (
  input  logic     aclk,
  input  logic     rst,

  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,   // Registered, no path from out_ready

  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  logic     full;       // Skid register holds an entry
  payload_t skid_data;

  // The skid register fills when a word arrives while downstream stalls.
  // It drains as soon as downstream takes it, and nothing new can enter
  // in that cycle because in_ready is still low.
  always_ff @(posedge aclk) begin
    if (rst) begin
      full <= 1'b0;
    end else if (full) begin
      if (out_ready) begin
        full <= 1'b0;            // Held entry leaves
      end
    end else if (in_valid && !out_ready) begin
      full <= 1'b1;              // Transfer in while stalled
    end
  end

  always_ff @(posedge aclk) begin
    if (!full && in_valid && !out_ready) begin
      skid_data <= in_data;      // Word that arrived during the stall
    end
  end

  assign in_ready  = !full;
  assign out_valid = full || in_valid;               // Pass-through when empty
  assign out_data  = full ? skid_data : in_data;

endmodule

/* hw/bram_pkg.sv */
package bram_pkg;

  // Memory geometry, 1024 words of 32 bits
  localparam int BRAM_DATA_WIDTH = 32;
  localparam int BRAM_ADDR_WIDTH = 10;                   // Word address
  localparam int BRAM_WE_WIDTH   = BRAM_DATA_WIDTH / 8;  // Byte enables

  // Byte-to-word address offset
  // Low bits of the AXI address pick a byte inside the word and are dropped
  localparam int ADDR_LSB = $clog2(BRAM_DATA_WIDTH / 8);

endpackage

/* hw/axi_pkg.sv */
package axi_pkg;

  // AXI4-Lite slave port geometry
  localparam int AXI_DATA_WIDTH = 32;                  // One bus word
  localparam int AXI_ADDR_WIDTH = 16;                  // Byte address
  localparam int AXI_STRB_WIDTH = AXI_DATA_WIDTH / 8;  // One strobe per byte lane

  // Response codes
  localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage
